//--- flist.f
verilog/host_proto_pkg.sv
verilog/aes_block_pkg.sv
verilog/host_link_fsm.sv
verilog/block_buffer.sv
verilog/aes_io_bridge.sv
verif/aes_io_bridge_properties.sv
verif/aes_io_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cipher I/O bridge testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module aes_io_bridge_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vaes_io_bridge_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
  exit 0
fi
exit 1

//--- verif/aes_io_bridge_properties.sv
/*
  Protocol checks for the cipher I/O bridge, bound to the top level.
  Covers the ready/status relation, the reset code and readback stability.
*/
`timescale 1ns/1ps

module aes_io_bridge_properties
  import host_proto_pkg::*;
(
  input logic       clk,
  input logic       reset_n,
  input sw_status_e to_sw_sig,
  input byte_t      to_sw_port,
  input logic       io_ready
);

  // Core request only while the host sees idle
  ready_means_idle: assert property (@(posedge clk) disable iff (!reset_n)
    io_ready |-> to_sw_sig == ST_IDLE)
    else $error("io_ready raised with a non-idle status");

  // Reset code lives only in the first cycle after release
  reset_code_once: assert property (@(posedge clk) disable iff (!reset_n)
    to_sw_sig == ST_RESET |-> !$past(reset_n))
    else $error("reset status seen outside the first cycle after reset");

  // Port reloads on the first edge of a busy span, then holds
  readback_stable: assert property (@(posedge clk) disable iff (!reset_n)
    (to_sw_sig == ST_BUSY_BYTE && $past(to_sw_sig) == ST_BUSY_BYTE &&
     $past(to_sw_sig, 2) == ST_BUSY_BYTE) |-> $stable(to_sw_port))
    else $error("to_sw_port changed while the busy status held");

endmodule

bind aes_io_bridge aes_io_bridge_properties props_i (
  .clk        (clk),
  .reset_n    (reset_n),
  .to_sw_sig  (to_sw_sig),
  .to_sw_port (to_sw_port),
  .io_ready   (io_ready)
);

//--- verif/aes_io_bridge_tb.sv
/*
  Testbench for the cipher I/O bridge.
  Plays the processor on the code/byte ports and the cipher core on the
  request and result ports, running directed tests with a result line each.
*/
`timescale 1ns/1ps

module aes_io_bridge_tb
  import host_proto_pkg::*, aes_block_pkg::*;
;

  localparam int WAIT_LIMIT = 200;

  logic       clk;
  logic       reset_n;
  host_cmd_e  to_hw_sig;
  byte_t      to_hw_port;
  sw_status_e to_sw_sig;
  byte_t      to_sw_port;
  aes_req_t   aes_req;
  block_t     msg_de;
  logic       aes_ready;

  logic [31:0]  rng_state;
  logic [127:0] msg_blk;
  logic [127:0] key_blk;
  logic [127:0] result_blk;
  int           error_count;
  int           tests_run;
  int           tests_failed;

  aes_io_bridge dut_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .to_hw_sig  (to_hw_sig),
    .to_hw_port (to_hw_port),
    .to_sw_sig  (to_sw_sig),
    .to_sw_port (to_sw_port),
    .aes_req    (aes_req),
    .msg_de     (msg_de),
    .aes_ready  (aes_ready)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic byte_t rand_byte();
    rng_state = xorshift32(rng_state);
    return rng_state[7:0];
  endfunction

  // Byte i of a block sits at bits [127-8i : 120-8i]
  function automatic logic [127:0] rand_block();
    logic [127:0] blk;
    blk = '0;
    for (int i = 0; i < BLOCK_BYTES; i++)
      blk[127-8*i -: 8] = rand_byte();
    return blk;
  endfunction

  task automatic advance_clock();
    @(posedge clk);
    #2;
  endtask

  task automatic compare_block(input string name, input block_t got, input block_t exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_status(input string name, input sw_status_e got,
                                input sw_status_e exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic wait_status(input sw_status_e exp);
    int cycles;
    cycles = 0;
    while (to_sw_sig !== exp && cycles < WAIT_LIMIT) begin
      advance_clock();
      cycles++;
    end
    if (to_sw_sig !== exp) begin
      $display("Timeout: status code %0d did not appear within %0d cycles", exp, WAIT_LIMIT);
      error_count++;
    end
  endtask

  task automatic wait_io_ready();
    int cycles;
    cycles = 0;
    while (aes_req.io_ready !== 1'b1 && cycles < WAIT_LIMIT) begin
      advance_clock();
      cycles++;
    end
    if (aes_req.io_ready !== 1'b1) begin
      $display("Timeout: io_ready was not raised within %0d cycles", WAIT_LIMIT);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d error(s)", name, error_count - errs_before);
      tests_failed++;
    end
  endtask

  // Code 1 strobes a byte, code 2 acks it, code 0 closes the block
  task automatic load_message(input logic [127:0] blk);
    for (int i = 0; i < BLOCK_BYTES; i++) begin
      to_hw_port = blk[127-8*i -: 8];
      to_hw_sig  = CMD_ONE;
      wait_status(ST_BUSY_BYTE);
      to_hw_sig = CMD_TWO;
      wait_status(ST_IDLE);
    end
    to_hw_sig = CMD_IDLE;
    advance_clock();
  endtask

  // Key codes are swapped, and code 3 closes the block
  task automatic load_key(input logic [127:0] blk);
    for (int i = 0; i < BLOCK_BYTES; i++) begin
      to_hw_port = blk[127-8*i -: 8];
      to_hw_sig  = CMD_TWO;
      wait_status(ST_BUSY_BYTE);
      to_hw_sig = CMD_ONE;
      wait_status(ST_IDLE);
    end
    to_hw_sig = CMD_THREE;
    advance_clock();
    // Drop code 3 before WAIT can take it as a run
    to_hw_sig = CMD_IDLE;
    advance_clock();
  endtask

  task automatic test_reset();
    int errs_before;
    errs_before = error_count;
    reset_n = 1'b0;
    advance_clock();
    compare_status("to_sw_sig", to_sw_sig, ST_RESET);
    compare_flag("io_ready", aes_req.io_ready, 1'b0);
    compare_block("msg_en", aes_req.msg_en, '0);
    compare_block("key", aes_req.key, '0);
    @(posedge clk);
    #2;
    reset_n = 1'b1;
    compare_status("to_sw_sig", to_sw_sig, ST_RESET);
    advance_clock();
    compare_status("to_sw_sig", to_sw_sig, ST_IDLE);
    compare_flag("io_ready", aes_req.io_ready, 1'b0);
    report_test("reset", errs_before);
  endtask

  task automatic test_message_load();
    int errs_before;
    errs_before = error_count;
    msg_blk = rand_block();
    load_message(msg_blk);
    compare_block("msg_en", aes_req.msg_en, msg_blk);
    compare_status("to_sw_sig", to_sw_sig, ST_IDLE);
    report_test("message_load", errs_before);
  endtask

  task automatic test_key_load();
    int errs_before;
    errs_before = error_count;
    key_blk = rand_block();
    load_key(key_blk);
    compare_block("key", aes_req.key, key_blk);
    compare_block("msg_en", aes_req.msg_en, msg_blk);
    compare_status("to_sw_sig", to_sw_sig, ST_IDLE);
    report_test("key_load", errs_before);
  endtask

  task automatic test_run_wait();
    int errs_before;
    errs_before = error_count;
    aes_ready = 1'b0;
    to_hw_sig = CMD_THREE;
    wait_io_ready();
    to_hw_sig = CMD_IDLE;
    compare_status("to_sw_sig", to_sw_sig, ST_IDLE);
    // Request holds through a core stall
    repeat (10) begin
      advance_clock();
      compare_flag("io_ready", aes_req.io_ready, 1'b1);
      compare_status("to_sw_sig", to_sw_sig, ST_IDLE);
    end
    result_blk = rand_block();
    msg_de     = result_blk;
    aes_ready  = 1'b1;
    wait_status(ST_RESULT);
    compare_flag("io_ready", aes_req.io_ready, 1'b0);
    aes_ready = 1'b0;
    report_test("run_wait", errs_before);
  endtask

  task automatic test_readback();
    int errs_before;
    errs_before = error_count;
    for (int i = 0; i < BLOCK_BYTES; i++) begin
      to_hw_sig = CMD_ONE;
      wait_status(ST_BUSY_BYTE);
      // Readback byte is registered one clock behind the status
      advance_clock();
      compare_byte("to_sw_port", to_sw_port, result_blk[127-8*i -: 8]);
      // Byte holds while the host delays the ack
      repeat (2) advance_clock();
      compare_byte("to_sw_port", to_sw_port, result_blk[127-8*i -: 8]);
      to_hw_sig = CMD_TWO;
      wait_status(ST_IDLE);
    end
    to_hw_sig = CMD_ONE;
    advance_clock();
    to_hw_sig = CMD_IDLE;
    advance_clock();
    compare_status("to_sw_sig", to_sw_sig, ST_IDLE);
    msg_blk = rand_block();
    load_message(msg_blk);
    compare_block("msg_en", aes_req.msg_en, msg_blk);
    report_test("readback", errs_before);
  endtask

  initial begin
    clk          = 1'b0;
    reset_n      = 1'b0;
    to_hw_sig    = CMD_IDLE;
    to_hw_port   = '0;
    msg_de       = '0;
    aes_ready    = 1'b0;
    rng_state    = 32'd10513;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_reset();
    test_message_load();
    test_key_load();
    test_run_wait();
    test_readback();
    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/aes_block_pkg.sv
/*
  Block-level types shared by the bridge and the cipher core.
  A block is 16 bytes with byte 0 in the top bits.
*/
package aes_block_pkg;

  import host_proto_pkg::*;

  // Ascending byte order puts element 0 at bits [127:120]
  typedef byte_t [0:BLOCK_BYTES-1] block_t;

  // Request bundle toward the cipher core
  typedef struct packed {
    block_t msg_en;
    block_t key;
    logic   io_ready;
  } aes_req_t;

  // Controller to buffer strobes
  typedef struct packed {
    logic      capture_msg;
    logic      capture_key;
    logic      load_out;
    byte_idx_t byte_idx;
  } buf_ctrl_t;

endpackage

//--- verilog/aes_io_bridge.sv
/*
  Host-side I/O bridge for a 128-bit block cipher.
  Loads message and key bytes from the processor, raises the ready level
  to the core, and streams the core result back one byte at a time.
*/
`timescale 1ns/1ps

module aes_io_bridge
  import host_proto_pkg::*, aes_block_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  host_cmd_e  to_hw_sig,
  input  byte_t      to_hw_port,
  output sw_status_e to_sw_sig,
  output byte_t      to_sw_port,
  output aes_req_t   aes_req,
  input  block_t     msg_de,
  input  logic       aes_ready
);

  buf_ctrl_t buf_ctrl;
  block_t    msg_en;
  block_t    key;
  logic      io_ready;

  host_link_fsm link_fsm_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .to_hw_sig (to_hw_sig),
    .aes_ready (aes_ready),
    .to_sw_sig (to_sw_sig),
    .io_ready  (io_ready),
    .buf_ctrl  (buf_ctrl)
  );

  block_buffer block_buf_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .buf_ctrl   (buf_ctrl),
    .to_hw_port (to_hw_port),
    .msg_de     (msg_de),
    .msg_en     (msg_en),
    .key        (key),
    .to_sw_port (to_sw_port)
  );

  // Core request bundle
  assign aes_req = '{msg_en: msg_en, key: key, io_ready: io_ready};

endmodule

//--- verilog/block_buffer.sv
/*
  Message, key and readback storage for the cipher I/O bridge.
  Host bytes land in the indexed slot of the message or key register,
  and the indexed result byte is registered onto the readback port.
*/
`timescale 1ns/1ps

module block_buffer
  import host_proto_pkg::*, aes_block_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  buf_ctrl_t buf_ctrl,
  input  byte_t     to_hw_port,
  input  block_t    msg_de,
  output block_t    msg_en,
  output block_t    key,
  output byte_t     to_sw_port
);

  // Slot keeps rewriting while the phase holds, so the last edge wins
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      msg_en <= '0;
    end else if (buf_ctrl.capture_msg) begin
      msg_en[buf_ctrl.byte_idx] <= to_hw_port;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      key <= '0;
    end else if (buf_ctrl.capture_key) begin
      key[buf_ctrl.byte_idx] <= to_hw_port;
    end
  end

  // Readback byte valid one clock after the busy status
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      to_sw_port <= '0;
    end else if (buf_ctrl.load_out) begin
      to_sw_port <= msg_de[buf_ctrl.byte_idx];
    end
  end

endmodule

//--- verilog/host_link_fsm.sv
/*
  Host link controller for the cipher I/O bridge.
  Tracks the transfer phase and byte index, decodes the processor codes,
  and drives the status code, the core ready level and the buffer strobes.
*/
`timescale 1ns/1ps

module host_link_fsm
  import host_proto_pkg::*, aes_block_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  host_cmd_e  to_hw_sig,
  input  logic       aes_ready,
  output sw_status_e to_sw_sig,
  output logic       io_ready,
  output buf_ctrl_t  buf_ctrl
);

  link_phase_e phase;
  link_phase_e next_phase;
  byte_idx_t   byte_idx;
  logic        idx_clr;
  logic        idx_inc;
  logic        last_byte;

  assign last_byte = (byte_idx == byte_idx_t'(BLOCK_BYTES - 1));

  always_comb begin
    next_phase = phase;
    idx_clr    = 1'b0;
    idx_inc    = 1'b0;
    unique case (phase)
      RESET: next_phase = WAIT;
      WAIT: begin
        idx_clr = 1'b1;
        if (to_hw_sig == CMD_ONE)
          next_phase = READ_MSG;
        else if (to_hw_sig == CMD_TWO)
          next_phase = READ_KEY;
        else if (to_hw_sig == CMD_THREE)
          next_phase = SEND_TO_AES;
      end
      READ_MSG: begin
        if (to_hw_sig == CMD_TWO)
          next_phase = ACK_MSG;
      end
      ACK_MSG: begin
        // Last message byte closes on idle code
        if (last_byte) begin
          if (to_hw_sig == CMD_IDLE)
            next_phase = WAIT;
        end else if (to_hw_sig == CMD_ONE) begin
          next_phase = READ_MSG;
          idx_inc    = 1'b1;
        end
      end
      READ_KEY: begin
        if (to_hw_sig == CMD_ONE)
          next_phase = ACK_KEY;
      end
      ACK_KEY: begin
        if (last_byte) begin
          if (to_hw_sig == CMD_THREE)
            next_phase = WAIT;
        end else if (to_hw_sig == CMD_TWO) begin
          next_phase = READ_KEY;
          idx_inc    = 1'b1;
        end
      end
      SEND_TO_AES: begin
        if (aes_ready)
          next_phase = GET_FROM_AES;
      end
      GET_FROM_AES: begin
        idx_clr = 1'b1;
        if (to_hw_sig == CMD_ONE)
          next_phase = SEND_BACK;
      end
      SEND_BACK: begin
        if (to_hw_sig == CMD_TWO)
          next_phase = GOT_ACK;
      end
      GOT_ACK: begin
        if (to_hw_sig == CMD_ONE) begin
          next_phase = last_byte ? WAIT : SEND_BACK;
          idx_inc    = !last_byte;
        end
      end
      default: next_phase = RESET;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      phase    <= RESET;
      byte_idx <= '0;
    end else begin
      phase <= next_phase;
      if (idx_clr)
        byte_idx <= '0;
      else if (idx_inc)
        byte_idx <= byte_idx + 1'b1;
    end
  end

  // Status follows the phase register directly
  always_comb begin
    unique case (phase)
      RESET:                         to_sw_sig = ST_RESET;
      READ_MSG, READ_KEY, SEND_BACK: to_sw_sig = ST_BUSY_BYTE;
      GET_FROM_AES:                  to_sw_sig = ST_RESULT;
      default:                       to_sw_sig = ST_IDLE;
    endcase
  end

  assign io_ready = (phase == SEND_TO_AES);

  always_comb begin
    buf_ctrl.capture_msg = (phase == READ_MSG);
    buf_ctrl.capture_key = (phase == READ_KEY);
    buf_ctrl.load_out    = (phase == SEND_BACK);
    buf_ctrl.byte_idx    = byte_idx;
  end

endmodule

//--- verilog/host_proto_pkg.sv
/*
  Host link protocol definitions for the cipher I/O bridge.
  Covers the 2-bit code pairs exchanged with the processor, the byte
  transfer unit, block byte count and the controller phases.
*/
package host_proto_pkg;

  localparam int BLOCK_BYTES = 16;

  typedef logic [7:0] byte_t;

  // Index 0 is the most significant byte of a block
  typedef logic [$clog2(BLOCK_BYTES)-1:0] byte_idx_t;

  // Meaning of each code depends on the current phase
  typedef enum logic [1:0] {
    CMD_IDLE  = 2'd0,
    CMD_ONE   = 2'd1,
    CMD_TWO   = 2'd2,
    CMD_THREE = 2'd3
  } host_cmd_e;

  // ST_IDLE doubles as the ack code
  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,
    ST_BUSY_BYTE = 2'd1,
    ST_RESULT    = 2'd2,
    ST_RESET     = 2'd3
  } sw_status_e;

  typedef enum logic [3:0] {
    RESET,
    WAIT,
    READ_MSG,
    ACK_MSG,
    READ_KEY,
    ACK_KEY,
    SEND_TO_AES,
    GET_FROM_AES,
    SEND_BACK,
    GOT_ACK
  } link_phase_e;

endpackage
